//--- include/core_defines.svh
/*
 * Core-wide constants for mini_core
 * Data width, register count, boot address and RV32I major opcodes
 */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data and address width
`define XLEN 32
// Architectural registers including x0
`define NUM_REGS 32
// First fetch address after reset
`define BOOT_ADDR 32'h0000_0000

// Major opcode field values, instr[6:0]
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111

`endif

//--- rtl/core_pkg.sv
/*
 * Shared types of mini_core
 * Instruction classes, ALU operations, controller states, decoded instruction
 */
`include "core_defines.svh"

package core_pkg;

  // Major instruction class
  typedef enum logic [2:0] {
    OP,
    OP_IMM,
    LUI,
    LOAD,
    STORE,
    BRANCH,
    JAL,
    ILLEGAL
  } opcode_e;

  // ALU operation select
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    PASS_B
  } alu_op_e;

  // Multicycle sequence, one instruction at a time
  typedef enum logic [1:0] {
    FETCH,
    EXECUTE,
    MEMORY,
    WRITEBACK
  } ctrl_state_e;

  // Decoder output
  typedef struct packed {
    opcode_e          opcode;
    alu_op_e          alu_op;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [4:0]       rd;
    logic [`XLEN-1:0] imm;
    // Operand b from the immediate
    logic             use_imm;
    logic             rf_we;
    // BNE rather than BEQ
    logic             br_ne;
  } decoded_t;

endpackage

//--- rtl/lsu_req_if.sv
/*
 * Load/store request channel
 * Controller issues one word access, the LSU answers with done and read data
 */
`timescale 1ns/1ns
`include "core_defines.svh"

interface lsu_req_if;

  // Request, held until done
  logic             req_valid;
  logic             req_we;
  logic [`XLEN-1:0] req_addr;
  logic [`XLEN-1:0] req_wdata;
  // Completion, one cycle
  logic             done;
  logic [`XLEN-1:0] rdata;

  modport controller (output req_valid, req_we, req_addr, req_wdata, input done, rdata);
  modport lsu (input req_valid, req_we, req_addr, req_wdata, output done, rdata);

endinterface

//--- rtl/fetch_unit.sv
/*
 * Fetch unit
 * Holds the PC and runs one OBI read on the instruction bus per fetch request
 */
`timescale 1ns/1ns
`include "core_defines.svh"

module fetch_unit (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             fetch_start_i,
  input  logic             pc_load_i,
  input  logic [`XLEN-1:0] next_pc_i,
  input  logic             instr_gnt_i,
  input  logic             instr_rvalid_i,
  input  logic [`XLEN-1:0] instr_rdata_i,
  output logic             instr_req_o,
  output logic [`XLEN-1:0] instr_addr_o,
  output logic [`XLEN-1:0] instr_o,
  output logic [`XLEN-1:0] pc_o,
  output logic             instr_valid_o
);

  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] instr_q;
  // Address phase open
  logic             req_q;
  // Waiting for rvalid
  logic             wait_q;
  logic             valid_q;

  // Program counter, loaded once per instruction in writeback
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q <= `BOOT_ADDR;
    end else if (pc_load_i) begin
      pc_q <= next_pc_i;
    end
  end

  // OBI master handshake
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q   <= 1'b0;
      wait_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= wait_q && instr_rvalid_i;
      // Address phase ends on gnt
      if (fetch_start_i) begin
        req_q <= 1'b1;
      end else if (req_q && instr_gnt_i) begin
        req_q <= 1'b0;
      end
      // Response phase ends on rvalid
      if (req_q && instr_gnt_i) begin
        wait_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  // Fetched word, held for the whole instruction
  always_ff @(posedge clk_i) begin
    if (wait_q && instr_rvalid_i) begin
      instr_q <= instr_rdata_i;
    end
  end

  assign instr_req_o   = req_q;
  // PC only moves in writeback, so the address is stable during req
  assign instr_addr_o  = pc_q;
  assign instr_o       = instr_q;
  assign pc_o          = pc_q;
  assign instr_valid_o = valid_q;

endmodule

//--- rtl/decoder.sv
/*
 * Instruction decoder
 * Register fields, immediate and ALU operation for the RV32I subset
 */
`timescale 1ns/1ns
`include "core_defines.svh"

module decoder import core_pkg::*; (
  input  logic [`XLEN-1:0] instr_i,
  output decoded_t         dec_o
);

  logic [6:0]       opc;
  logic [2:0]       funct3;
  logic             funct7_b5;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;

  assign opc       = instr_i[6:0];
  assign funct3    = instr_i[14:12];
  assign funct7_b5 = instr_i[30];

  // Sign-extended immediates per format
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    // Default is a no-op
    dec_o.opcode  = ILLEGAL;
    dec_o.alu_op  = ADD;
    dec_o.rs1     = instr_i[15 +: $clog2(`NUM_REGS)];
    dec_o.rs2     = instr_i[20 +: $clog2(`NUM_REGS)];
    dec_o.rd      = instr_i[7 +: $clog2(`NUM_REGS)];
    dec_o.imm     = imm_i;
    dec_o.use_imm = 1'b0;
    dec_o.rf_we   = 1'b0;
    dec_o.br_ne   = funct3[0];

    case (opc)
      `OPC_OP: begin
        dec_o.opcode = OP;
        dec_o.rf_we  = 1'b1;
      end
      `OPC_OP_IMM: begin
        dec_o.opcode  = OP_IMM;
        dec_o.use_imm = 1'b1;
        dec_o.rf_we   = 1'b1;
      end
      `OPC_LUI: begin
        dec_o.opcode  = LUI;
        dec_o.alu_op  = PASS_B;
        dec_o.imm     = imm_u;
        dec_o.use_imm = 1'b1;
        dec_o.rf_we   = 1'b1;
      end
      // Word accesses only
      `OPC_LOAD: begin
        if (funct3 == 3'b010) begin
          dec_o.opcode  = LOAD;
          dec_o.use_imm = 1'b1;
          dec_o.rf_we   = 1'b1;
        end
      end
      `OPC_STORE: begin
        if (funct3 == 3'b010) begin
          dec_o.opcode  = STORE;
          dec_o.imm     = imm_s;
          dec_o.use_imm = 1'b1;
        end
      end
      // BEQ and BNE, compared through the ALU
      `OPC_BRANCH: begin
        if (funct3[2:1] == 2'b00) begin
          dec_o.opcode = BRANCH;
          dec_o.alu_op = SUB;
          dec_o.imm    = imm_b;
        end
      end
      `OPC_JAL: begin
        dec_o.opcode = JAL;
        dec_o.imm    = imm_j;
        dec_o.rf_we  = 1'b1;
      end
      default: ;
    endcase

    // funct3/funct7 to ALU operation
    if (dec_o.opcode inside {OP, OP_IMM}) begin
      case (funct3)
        3'b000: dec_o.alu_op = (dec_o.opcode == OP && funct7_b5) ? SUB : ADD;
        3'b010: dec_o.alu_op = SLT;
        3'b100: dec_o.alu_op = XOR;
        3'b110: dec_o.alu_op = OR;
        3'b111: dec_o.alu_op = AND;
        // Shifts and SLTU not supported
        default: begin
          dec_o.opcode = ILLEGAL;
          dec_o.rf_we  = 1'b0;
        end
      endcase
    end
  end

endmodule

//--- rtl/alu.sv
/*
 * ALU
 * Add, subtract, logic, signed compare and branch equality
 */
`timescale 1ns/1ns
`include "core_defines.svh"

module alu import core_pkg::*; (
  input  alu_op_e          op_i,
  input  logic [`XLEN-1:0] a_i,
  input  logic [`XLEN-1:0] b_i,
  output logic [`XLEN-1:0] result_o,
  output logic             equal_o
);

  logic lt_signed;

  // Signed less-than for SLT and SLTI
  assign lt_signed = $signed(a_i) < $signed(b_i);

  always_comb begin
    unique case (op_i)
      ADD:     result_o = a_i + b_i;
      SUB:     result_o = a_i - b_i;
      AND:     result_o = a_i & b_i;
      OR:      result_o = a_i | b_i;
      XOR:     result_o = a_i ^ b_i;
      SLT:     result_o = {{(`XLEN-1){1'b0}}, lt_signed};
      // LUI immediate straight through
      PASS_B:  result_o = b_i;
      default: result_o = '0;
    endcase
  end

  // Branch condition for BEQ and BNE
  assign equal_o = (a_i == b_i);

endmodule

//--- rtl/register_file.sv
/*
 * Register file
 * 32 x 32 bits, two combinational reads and one write, x0 hardwired to zero
 */
`timescale 1ns/1ns
`include "core_defines.svh"

module register_file (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic [4:0]       raddr_a_i,
  input  logic [4:0]       raddr_b_i,
  input  logic [4:0]       waddr_i,
  input  logic             we_i,
  input  logic [`XLEN-1:0] wdata_i,
  output logic [`XLEN-1:0] rdata_a_o,
  output logic [`XLEN-1:0] rdata_b_o
);

  // x0 has no storage
  logic [`XLEN-1:0] regs_q [1:`NUM_REGS-1];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < `NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Reads see the old value until the cycle after a write
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- rtl/load_store_unit.sv
/*
 * Load/store unit
 * Turns one controller request into one word transaction on the data bus
 */
`timescale 1ns/1ns
`include "core_defines.svh"

module load_store_unit (
  input  logic             clk_i,
  input  logic             rst_i,
  lsu_req_if.lsu           req,
  input  logic             data_gnt_i,
  input  logic             data_rvalid_i,
  input  logic [`XLEN-1:0] data_rdata_i,
  output logic             data_req_o,
  output logic             data_we_o,
  output logic [3:0]       data_be_o,
  output logic [`XLEN-1:0] data_addr_o,
  output logic [`XLEN-1:0] data_wdata_o
);

  // Bus phases
  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    RESP
  } lsu_state_e;

  lsu_state_e       state_q;
  logic             we_q;
  logic [`XLEN-1:0] addr_q;
  logic [`XLEN-1:0] wdata_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      unique case (state_q)
        IDLE:    if (req.req_valid) state_q <= ADDR;
        ADDR:    if (data_gnt_i) state_q <= RESP;
        RESP:    if (data_rvalid_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request captured once, kept stable through the address phase
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req.req_valid) begin
      we_q    <= req.req_we;
      addr_q  <= req.req_addr;
      wdata_q <= req.req_wdata;
    end
  end

  assign data_req_o   = (state_q == ADDR);
  assign data_we_o    = we_q;
  // Word accesses only
  assign data_be_o    = 4'hF;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;

  // Done with rvalid, so req_valid is already gone when IDLE is seen again
  assign req.done  = (state_q == RESP) && data_rvalid_i;
  assign req.rdata = data_rdata_i;

endmodule

//--- rtl/core_controller.sv
/*
 * Core controller
 * Sequences fetch, execute, memory and writeback and picks the next PC
 */
`timescale 1ns/1ns
`include "core_defines.svh"

module core_controller import core_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             instr_valid_i,
  input  logic [`XLEN-1:0] pc_i,
  input  decoded_t         dec_i,
  input  logic [`XLEN-1:0] rs1_data_i,
  input  logic [`XLEN-1:0] rs2_data_i,
  input  logic [`XLEN-1:0] alu_result_i,
  input  logic             alu_equal_i,
  output logic             fetch_start_o,
  output logic             pc_load_o,
  output logic [`XLEN-1:0] next_pc_o,
  output alu_op_e          alu_op_o,
  output logic [`XLEN-1:0] alu_a_o,
  output logic [`XLEN-1:0] alu_b_o,
  output logic             rf_we_o,
  output logic [`XLEN-1:0] rf_wdata_o,
  lsu_req_if.controller    lsu
);

  ctrl_state_e      state_q;
  ctrl_state_e      state_d;
  // First fetch after reset
  logic             boot_q;
  logic [`XLEN-1:0] load_q;
  logic [`XLEN-1:0] pc_plus4;
  logic [`XLEN-1:0] pc_target;
  logic             is_mem;
  logic             br_taken;

  assign is_mem = dec_i.opcode inside {LOAD, STORE};

  //////////////////////////////
  // State sequence
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      FETCH:     if (instr_valid_i) state_d = EXECUTE;
      EXECUTE:   state_d = is_mem ? MEMORY : WRITEBACK;
      MEMORY:    if (lsu.done) state_d = WRITEBACK;
      WRITEBACK: state_d = FETCH;
      default:   state_d = FETCH;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= FETCH;
      boot_q  <= 1'b1;
    end else begin
      state_q <= state_d;
      boot_q  <= 1'b0;
    end
  end

  // Load data arrives for one cycle only
  always_ff @(posedge clk_i) begin
    if (lsu.done) begin
      load_q <= lsu.rdata;
    end
  end

  //////////////////////////////
  // Datapath control
  //////////////////////////////

  // Operands, immediate forms use b
  assign alu_op_o = dec_i.alu_op;
  assign alu_a_o  = rs1_data_i;
  assign alu_b_o  = dec_i.use_imm ? dec_i.imm : rs2_data_i;

  // Address from rs1 + imm, fields held through MEMORY
  assign lsu.req_valid = (state_q == MEMORY);
  assign lsu.req_we    = (dec_i.opcode == STORE);
  assign lsu.req_addr  = alu_result_i;
  assign lsu.req_wdata = rs2_data_i;

  // Writeback source
  assign rf_we_o = (state_q == WRITEBACK) && dec_i.rf_we;
  always_comb begin
    case (dec_i.opcode)
      LOAD:    rf_wdata_o = load_q;
      // Link address
      JAL:     rf_wdata_o = pc_plus4;
      default: rf_wdata_o = alu_result_i;
    endcase
  end

  //////////////////////////////
  // Next PC
  //////////////////////////////

  assign pc_plus4  = pc_i + `XLEN'd4;
  // Branch and jump offsets share one adder
  assign pc_target = pc_i + dec_i.imm;
  assign br_taken  = (dec_i.opcode == BRANCH) && (alu_equal_i ^ dec_i.br_ne);

  assign next_pc_o = (br_taken || dec_i.opcode == JAL) ? pc_target : pc_plus4;
  assign pc_load_o = (state_q == WRITEBACK);

  // Next request one cycle after writeback or after reset release
  assign fetch_start_o = boot_q || (state_q == WRITEBACK);

endmodule

//--- rtl/mini_core.sv
/*
 * mini_core top level
 * Multicycle RV32I subset core with OBI instruction and data buses
 */
`timescale 1ns/1ns
`include "core_defines.svh"

module mini_core import core_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_i,
  // Instruction bus
  output logic             instr_req_o,
  output logic [`XLEN-1:0] instr_addr_o,
  input  logic             instr_gnt_i,
  input  logic             instr_rvalid_i,
  input  logic [`XLEN-1:0] instr_rdata_i,
  // Data bus
  output logic             data_req_o,
  output logic             data_we_o,
  output logic [3:0]       data_be_o,
  output logic [`XLEN-1:0] data_addr_o,
  output logic [`XLEN-1:0] data_wdata_o,
  input  logic             data_gnt_i,
  input  logic             data_rvalid_i,
  input  logic [`XLEN-1:0] data_rdata_i
);

  // Fetch and controller
  logic             fetch_start;
  logic             pc_load;
  logic [`XLEN-1:0] next_pc;
  logic [`XLEN-1:0] instr;
  logic [`XLEN-1:0] pc;
  logic             instr_valid;
  decoded_t         dec;
  // Register file
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic             rf_we;
  logic [`XLEN-1:0] rf_wdata;
  // ALU
  alu_op_e          alu_op;
  logic [`XLEN-1:0] alu_a;
  logic [`XLEN-1:0] alu_b;
  logic [`XLEN-1:0] alu_result;
  logic             alu_equal;

  lsu_req_if lsu_if ();

  //////////////////////////////
  // Fetch and decode
  //////////////////////////////

  fetch_unit fetch_unit_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch_start_i  (fetch_start),
    .pc_load_i      (pc_load),
    .next_pc_i      (next_pc),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_o        (instr),
    .pc_o           (pc),
    .instr_valid_o  (instr_valid)
  );

  decoder decoder_i (
    .instr_i (instr),
    .dec_o   (dec)
  );

  //////////////////////////////
  // Execute
  //////////////////////////////

  register_file register_file_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raddr_a_i (dec.rs1),
    .raddr_b_i (dec.rs2),
    .waddr_i   (dec.rd),
    .we_i      (rf_we),
    .wdata_i   (rf_wdata),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data)
  );

  alu alu_i (
    .op_i     (alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_result),
    .equal_o  (alu_equal)
  );

  load_store_unit load_store_unit_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req           (lsu_if.lsu),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .data_req_o    (data_req_o),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o)
  );

  //////////////////////////////
  // Control
  //////////////////////////////

  core_controller core_controller_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid),
    .pc_i          (pc),
    .dec_i         (dec),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .alu_result_i  (alu_result),
    .alu_equal_i   (alu_equal),
    .fetch_start_o (fetch_start),
    .pc_load_o     (pc_load),
    .next_pc_o     (next_pc),
    .alu_op_o      (alu_op),
    .alu_a_o       (alu_a),
    .alu_b_o       (alu_b),
    .rf_we_o       (rf_we),
    .rf_wdata_o    (rf_wdata),
    .lsu           (lsu_if.controller)
  );

endmodule

//--- bench/mini_core_assertions.sv
/*
 * OBI protocol assertions for mini_core
 * Address stability, single outstanding transaction, byte enables, reset
 */
`timescale 1ns/1ns
`include "core_defines.svh"

module mini_core_assertions (
  input logic             clk_i,
  input logic             rst_i,
  input logic             instr_req_o,
  input logic [`XLEN-1:0] instr_addr_o,
  input logic             instr_gnt_i,
  input logic             instr_rvalid_i,
  input logic             data_req_o,
  input logic             data_we_o,
  input logic [3:0]       data_be_o,
  input logic [`XLEN-1:0] data_addr_o,
  input logic [`XLEN-1:0] data_wdata_o,
  input logic             data_gnt_i,
  input logic             data_rvalid_i
);

  // Granted but not yet answered
  logic instr_pend_q;
  logic data_pend_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      instr_pend_q <= 1'b0;
      data_pend_q  <= 1'b0;
    end else begin
      if (instr_req_o && instr_gnt_i) instr_pend_q <= 1'b1;
      else if (instr_rvalid_i) instr_pend_q <= 1'b0;
      if (data_req_o && data_gnt_i) data_pend_q <= 1'b1;
      else if (data_rvalid_i) data_pend_q <= 1'b0;
    end
  end

  //////////////////////////////
  // Address phase stability
  //////////////////////////////

  instr_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("instruction request changed before gnt");

  data_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o)
      && $stable(data_we_o) && $stable(data_wdata_o))
    else $error("data request changed before gnt");

  // One transaction at a time
  instr_single_a: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_pend_q |-> !instr_req_o)
    else $error("instruction request before rvalid");

  data_single_a: assert property (@(posedge clk_i) disable iff (rst_i)
    data_pend_q |-> !data_req_o)
    else $error("data request before rvalid");

  data_be_a: assert property (@(posedge clk_i) disable iff (rst_i)
    data_req_o |-> data_be_o == 4'hF)
    else $error("data byte enables not all ones");

  // Quiet through reset and the release cycle
  reset_quiet_a: assert property (@(posedge clk_i)
    rst_i |=> !instr_req_o && !data_req_o)
    else $error("bus request during reset");

endmodule

bind mini_core mini_core_assertions asrt (.*);

//--- bench/mini_core_tb.sv
/*
 * mini_core testbench
 * OBI memory models with random delays, directed program tests, watchdog
 */
`timescale 1ns/1ns
`include "core_defines.svh"

module mini_core_tb;

  localparam int NUM_TESTS  = 4;
  localparam int MAX_PROG   = 32;
  // Fetch and memory access each up to about 10 cycles
  localparam int WORST_CPI  = 30;
  localparam int TIMEOUT_NS = NUM_TESTS * MAX_PROG * WORST_CPI * 10;
  localparam logic [31:0] DONE_ADDR = 32'h0000_1000;

  logic clk_i = 1'b0;
  logic rst_i = 1'b1;
  logic instr_req_o, instr_gnt_i, instr_rvalid_i;
  logic [31:0] instr_addr_o, instr_rdata_i;
  logic data_req_o, data_we_o, data_gnt_i, data_rvalid_i;
  logic [3:0] data_be_o;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_i;

  logic [31:0] imem [0:63];
  logic [31:0] dmem [0:255];
  logic [31:0] prog [$];
  // Memory models answer only while enabled
  logic bus_en = 1'b0;
  logic ibusy = 1'b0;
  logic dbusy = 1'b0;
  logic done_seen = 1'b0;
  logic seen_ireq, seen_dreq, first_dwe;
  logic [31:0] first_iaddr;
  logic [31:0] first_daddr;

  mini_core dut (.*);

  always #5 clk_i = ~clk_i;

  initial begin
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = '0;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i = '0;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the core did not reach the end of its program in time");
    $display("Simulation failed");
    $fatal(1);
  end

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ 32'h5A5A_5A5A;
  endfunction

  ////////////////////////////////
  // OBI memory models
  ////////////////////////////////

  always begin : instr_bus_model
    int unsigned wait_cycles;
    logic [31:0] addr;
    @(posedge clk_i);
    #1;
    if (bus_en && instr_req_o) begin
      ibusy = 1'b1;
      if (!seen_ireq) begin
        first_iaddr = instr_addr_o;
        seen_ireq = 1'b1;
      end
      wait_cycles = $urandom_range(0, 3);
      repeat (wait_cycles) begin
        @(posedge clk_i);
        #1;
      end
      instr_gnt_i = 1'b1;
      addr = instr_addr_o;
      @(posedge clk_i);
      #1;
      instr_gnt_i = 1'b0;
      wait_cycles = $urandom_range(0, 3);
      repeat (wait_cycles) begin
        @(posedge clk_i);
        #1;
      end
      instr_rvalid_i = 1'b1;
      instr_rdata_i = imem[addr[7:2]];
      @(posedge clk_i);
      #1;
      instr_rvalid_i = 1'b0;
      ibusy = 1'b0;
    end
  end

  always begin : data_bus_model
    int unsigned wait_cycles;
    logic [31:0] rdata;
    @(posedge clk_i);
    #1;
    if (bus_en && data_req_o) begin
      dbusy = 1'b1;
      if (!seen_dreq) begin
        first_dwe = data_we_o;
        first_daddr = data_addr_o;
        seen_dreq = 1'b1;
      end
      wait_cycles = $urandom_range(0, 3);
      repeat (wait_cycles) begin
        @(posedge clk_i);
        #1;
      end
      data_gnt_i = 1'b1;
      // Outside the array reads the fill pattern
      rdata = (data_addr_o[31:10] == '0) ? dmem[data_addr_o[9:2]] : fill_word(data_addr_o);
      if (data_we_o && data_addr_o == DONE_ADDR) done_seen = 1'b1;
      else if (data_we_o && data_addr_o[31:10] == '0) dmem[data_addr_o[9:2]] = data_wdata_o;
      @(posedge clk_i);
      #1;
      data_gnt_i = 1'b0;
      wait_cycles = $urandom_range(0, 3);
      repeat (wait_cycles) begin
        @(posedge clk_i);
        #1;
      end
      data_rvalid_i = 1'b1;
      data_rdata_i = rdata;
      @(posedge clk_i);
      #1;
      data_rvalid_i = 1'b0;
      dbusy = 1'b0;
    end
  end

  ////////////////////////////////
  // Instruction encoders
  ////////////////////////////////

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, `OPC_LUI};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
  endfunction

  ////////////////////////////////
  // Run and check
  ////////////////////////////////

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_word(input logic [31:0] addr, input logic [31:0] exp);
    check($sformatf("dmem[%h]", addr), dmem[addr[9:2]], exp);
  endtask

  // Loads the program with its end marker, resets the core and runs to the marker
  task automatic run_program(input logic [31:0] first_store);
    prog.push_back(enc_u(20'h00001, 5'd31));
    prog.push_back(enc_s(12'd0, 5'd0, 5'd31));
    prog.push_back(enc_j(21'd0, 5'd0));
    for (int i = 0; i < 64; i++) imem[i] = (i < prog.size()) ? prog[i] : {25'(i), 7'h7f};
    for (int i = 0; i < 256; i++) dmem[i] = fill_word(32'(i * 4));
    prog.delete();
    @(posedge clk_i);
    #1;
    rst_i = 1'b1;
    done_seen = 1'b0;
    seen_ireq = 1'b0;
    seen_dreq = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    bus_en = 1'b1;
    wait (done_seen);
    @(posedge clk_i);
    #1;
    bus_en = 1'b0;
    @(posedge clk_i);
    wait (!ibusy && !dbusy);
    check("first instr_addr_o", first_iaddr, `BOOT_ADDR);
    // First data access is the program's first store
    check("first data_we_o", {31'd0, first_dwe}, 32'd1);
    check("first data_addr_o", first_daddr, first_store);
  endtask

  task automatic alu_ops_test();
    logic [31:0] a;
    logic [31:0] b;
    a = -32'd7;
    b = 32'd25;
    prog.push_back(enc_i(-12'd7, 5'd0, 3'b000, 5'd1, `OPC_OP_IMM));
    prog.push_back(enc_i(12'd25, 5'd0, 3'b000, 5'd2, `OPC_OP_IMM));
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    prog.push_back(enc_s(12'd0, 5'd3, 5'd0));
    prog.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
    prog.push_back(enc_s(12'd4, 5'd4, 5'd0));
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
    prog.push_back(enc_s(12'd8, 5'd5, 5'd0));
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
    prog.push_back(enc_s(12'd12, 5'd6, 5'd0));
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
    prog.push_back(enc_s(12'd16, 5'd7, 5'd0));
    prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd8));
    prog.push_back(enc_s(12'd20, 5'd8, 5'd0));
    prog.push_back(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd9));
    prog.push_back(enc_s(12'd24, 5'd9, 5'd0));
    prog.push_back(enc_i(12'h00f, 5'd2, 3'b111, 5'd10, `OPC_OP_IMM));
    prog.push_back(enc_s(12'd28, 5'd10, 5'd0));
    prog.push_back(enc_i(12'h100, 5'd2, 3'b110, 5'd11, `OPC_OP_IMM));
    prog.push_back(enc_s(12'd32, 5'd11, 5'd0));
    prog.push_back(enc_i(12'hfff, 5'd2, 3'b100, 5'd12, `OPC_OP_IMM));
    prog.push_back(enc_s(12'd36, 5'd12, 5'd0));
    prog.push_back(enc_i(-12'd3, 5'd1, 3'b010, 5'd13, `OPC_OP_IMM));
    prog.push_back(enc_s(12'd40, 5'd13, 5'd0));
    run_program(32'd0);
    check_word(32'd0, a + b);
    check_word(32'd4, a - b);
    check_word(32'd8, a & b);
    check_word(32'd12, a | b);
    check_word(32'd16, a ^ b);
    check_word(32'd20, {31'd0, $signed(a) < $signed(b)});
    check_word(32'd24, {31'd0, $signed(b) < $signed(a)});
    check_word(32'd28, b & 32'h0000_000f);
    check_word(32'd32, b | 32'h0000_0100);
    check_word(32'd36, b ^ 32'hffff_ffff);
    check_word(32'd40, {31'd0, $signed(a) < $signed(-32'sd3)});
  endtask

  task automatic lui_x0_test();
    prog.push_back(enc_u(20'habcde, 5'd5));
    prog.push_back(enc_s(12'd0, 5'd5, 5'd0));
    prog.push_back(enc_i(12'd55, 5'd0, 3'b000, 5'd0, `OPC_OP_IMM));
    prog.push_back(enc_s(12'd4, 5'd0, 5'd0));
    prog.push_back(enc_u(20'h80000, 5'd6));
    prog.push_back(enc_i(-12'd1, 5'd6, 3'b000, 5'd6, `OPC_OP_IMM));
    prog.push_back(enc_s(12'd8, 5'd6, 5'd0));
    run_program(32'd0);
    check_word(32'd0, {20'habcde, 12'd0});
    check_word(32'd4, 32'd0);
    check_word(32'd8, {20'h80000, 12'd0} - 32'd1);
  endtask

  task automatic load_store_test();
    prog.push_back(enc_i(12'h123, 5'd0, 3'b000, 5'd1, `OPC_OP_IMM));
    prog.push_back(enc_u(20'h5a5a5, 5'd2));
    prog.push_back(enc_i(12'h03c, 5'd2, 3'b000, 5'd2, `OPC_OP_IMM));
    prog.push_back(enc_s(12'd64, 5'd2, 5'd0));
    prog.push_back(enc_s(12'd68, 5'd1, 5'd0));
    prog.push_back(enc_i(12'd64, 5'd0, 3'b010, 5'd3, `OPC_LOAD));
    prog.push_back(enc_i(12'd68, 5'd0, 3'b010, 5'd4, `OPC_LOAD));
    prog.push_back(enc_i(12'd128, 5'd0, 3'b010, 5'd5, `OPC_LOAD));
    prog.push_back(enc_s(12'd72, 5'd3, 5'd0));
    prog.push_back(enc_s(12'd76, 5'd4, 5'd0));
    prog.push_back(enc_s(12'd80, 5'd5, 5'd0));
    run_program(32'd64);
    check_word(32'd64, 32'h5a5a_503c);
    check_word(32'd72, 32'h5a5a_503c);
    check_word(32'd76, 32'h0000_0123);
    check_word(32'd80, fill_word(32'd128));
  endtask

  task automatic branch_jal_test();
    prog.push_back(enc_i(12'd5, 5'd0, 3'b000, 5'd1, `OPC_OP_IMM));
    prog.push_back(enc_i(12'd5, 5'd0, 3'b000, 5'd2, `OPC_OP_IMM));
    prog.push_back(enc_i(12'd9, 5'd0, 3'b000, 5'd3, `OPC_OP_IMM));
    // Taken BEQ skips the store at 0
    prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b000));
    prog.push_back(enc_s(12'd0, 5'd3, 5'd0));
    prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b001));
    prog.push_back(enc_s(12'd4, 5'd1, 5'd0));
    prog.push_back(enc_b(13'd8, 5'd3, 5'd1, 3'b000));
    prog.push_back(enc_s(12'd8, 5'd2, 5'd0));
    prog.push_back(enc_b(13'd8, 5'd3, 5'd1, 3'b001));
    prog.push_back(enc_s(12'd12, 5'd3, 5'd0));
    // JAL at 44 jumps to 52 and links 48
    prog.push_back(enc_j(21'd8, 5'd5));
    prog.push_back(enc_s(12'd16, 5'd3, 5'd0));
    prog.push_back(enc_s(12'd20, 5'd5, 5'd0));
    run_program(32'd4);
    check_word(32'd0, fill_word(32'd0));
    check_word(32'd4, 32'd5);
    check_word(32'd8, 32'd5);
    check_word(32'd12, fill_word(32'd12));
    check_word(32'd16, fill_word(32'd16));
    check_word(32'd20, 32'd44 + 32'd4);
  endtask

  initial begin
    void'($urandom(32'h4f87_a607));
    alu_ops_test();
    lui_x0_test();
    load_store_test();
    branch_jal_test();
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- mini_core.f
+incdir+include
rtl/core_pkg.sv
rtl/lsu_req_if.sv
rtl/fetch_unit.sv
rtl/decoder.sv
rtl/alu.sv
rtl/register_file.sv
rtl/load_store_unit.sv
rtl/core_controller.sv
rtl/mini_core.sv
bench/mini_core_assertions.sv
bench/mini_core_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f mini_core.f --top-module mini_core_tb -o vsim
	./obj_dir/vsim | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
